// File: list.f
hdl/icache_pkg.sv
hdl/l2_bus_if.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_ctrl.sv
hdl/l2_arbiter.sv
hdl/l2_memory.sv
hdl/icache_top.sv
tests/tb_clock_gen.sv
tests/tb_icache_top.sv

// File: Bender.yml
package:
  name: icache

sources:
  - hdl/icache_pkg.sv
  - hdl/l2_bus_if.sv
  - hdl/icache_tag_array.sv
  - hdl/icache_data_array.sv
  - hdl/icache_ctrl.sv
  - hdl/l2_arbiter.sv
  - hdl/l2_memory.sv
  - hdl/icache_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_icache_top.sv

// File: tests/tb_icache_top.sv
/*
 * Testbench for the two-port instruction cache subsystem.
 * Memory is loaded with a random image before any fetch, since cached
 * lines do not follow later memory writes. One fetch in flight per port.
 */
`timescale 1ns/1ps

module tb_icache_top import icache_pkg::*; ();

    localparam int PERIOD      = 100;
    localparam int L2_LATENCY  = 4;
    localparam int MEM_LINES   = 1024;
    localparam int N_RAND      = 40;                  // random fetches per port
    localparam int NUM_FETCHES = 15 + 2 * N_RAND;
    localparam int FETCH_LIMIT = 2 * (L2_LATENCY + 12);
    localparam int RUN_CYCLES  = MEM_LINES + 20 + NUM_FETCHES * (L2_LATENCY + 12);

    logic       clk;
    logic       arst_n;
    logic       fetch_req_0;
    addr_t      fetch_addr_0;
    thread_t    fetch_thread_0;
    logic       fetch_rdy_0;
    word_t      fetch_data_0;
    logic       fetch_hit_0;
    logic       fetch_busy_0;
    logic       fetch_req_1;
    addr_t      fetch_addr_1;
    thread_t    fetch_thread_1;
    logic       fetch_rdy_1;
    word_t      fetch_data_1;
    logic       fetch_hit_1;
    logic       fetch_busy_1;
    logic       mem_wr_en;
    line_addr_t mem_wr_line;
    line_t      mem_wr_data;

    integer  seed = 50;
    line_t   mem_img   [MEM_LINES];         // copy of the loaded image
    logic    m_valid   [2][2][NUM_SETS];    // model: port, way, set
    tag_t    m_tag     [2][2][NUM_SETS];
    thread_t m_thread  [2][2][NUM_SETS];
    line_t   m_line    [2][2][NUM_SETS];
    logic    m_lru     [2][NUM_SETS];
    logic    exp_hit   [2];
    word_t   exp_word  [2];
    logic    pending   [2];
    addr_t   rand_addr [2][N_RAND];
    thread_t rand_thr  [2][N_RAND];
    int      issued    = 0;
    int      completed = 0;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    icache_top #(.L2_LATENCY(L2_LATENCY), .MEM_LINES(MEM_LINES)) i_dut (.*);

    ///////////////////////////////////////////////////////////////////////
    // error reporting and compare tasks
    ///////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input int p, input word_t got, input word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: port %0d fetch_data %h, expected %h",
                                    $time, p, got, exp));
    endtask

    task automatic check_hit(input int p, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: port %0d fetch_hit %b, expected %b",
                                    $time, p, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                    $time, name, got, exp));
    endtask

    task automatic check_cycles(input int p, input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("MISMATCH at %0t: port %0d hit took %0d cycles, expected %0d",
                                    $time, p, got, exp));
    endtask

    ///////////////////////////////////////////////////////////////////////
    // reference model of one L1 cache per port
    ///////////////////////////////////////////////////////////////////////
    function automatic void ref_fetch(input int p, input addr_t a, input thread_t t,
                                      output logic hit, output word_t word);
        index_t idx;
        tag_t   tg;
        logic   way;
        idx = a[9:2];
        tg  = a[29:10];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[p][w][idx] && m_tag[p][w][idx] == tg && m_thread[p][w][idx] == t) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            if (!m_valid[p][0][idx])      way = 1'b0;   // empty way first
            else if (!m_valid[p][1][idx]) way = 1'b1;
            else                          way = m_lru[p][idx];
            m_valid[p][way][idx]  = 1'b1;
            m_tag[p][way][idx]    = tg;
            m_thread[p][way][idx] = t;
            m_line[p][way][idx]   = mem_img[a[29:2] % MEM_LINES];
        end
        m_lru[p][idx] = ~way;
        word = m_line[p][way][idx][a[1:0]];
    endfunction

    function automatic addr_t make_addr(input tag_t tg, input index_t idx, input word_sel_t w);
        return {tg, idx, w};
    endfunction

    function automatic logic port_ready(input int p);
        return (p == 0) ? fetch_rdy_0 : fetch_rdy_1;
    endfunction

    function automatic logic port_busy(input int p);
        return (p == 0) ? fetch_busy_0 : fetch_busy_1;
    endfunction

    task automatic drive_req(input int p, input logic req, input addr_t a, input thread_t t);
        if (p == 0) begin
            fetch_req_0    <= req;
            fetch_addr_0   <= a;
            fetch_thread_0 <= t;
        end else begin
            fetch_req_1    <= req;
            fetch_addr_1   <= a;
            fetch_thread_1 <= t;
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < 4; w++) begin
                mem_img[i][w] = $random(seed);
            end
            @(posedge clk);
            mem_wr_en   <= 1'b1;
            mem_wr_line <= line_addr_t'(i);
            mem_wr_data <= mem_img[i];
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    // one fetch, waits for fetch_rdy; results are checked by the compare process
    task automatic fetch(input int p, input addr_t a, input thread_t t);
        logic  hit;
        word_t word;
        int    n;
        n = 0;
        @(posedge clk);
        ref_fetch(p, a, t, hit, word);
        exp_hit[p]  = hit;
        exp_word[p] = word;
        pending[p]  = 1'b1;
        issued++;
        drive_req(p, 1'b1, a, t);
        do begin
            @(posedge clk);
            n++;
            if (n == 1) drive_req(p, 1'b0, a, t);
            @(negedge clk);
            if (n > FETCH_LIMIT)
                stop_on_error($sformatf("port %0d fetch of %h never became ready", p, a));
            check_flag($sformatf("fetch_busy_%0d", p), port_busy(p), 1'b1);
        end while (!port_ready(p));
        if (hit) check_cycles(p, n, 2);
    endtask

    // compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (port_ready(p) === 1'b1) begin
                if (!pending[p])
                    stop_on_error($sformatf("port %0d raised fetch_rdy with no fetch pending", p));
                check_hit(p, (p == 0) ? fetch_hit_0 : fetch_hit_1, exp_hit[p]);
                check_word(p, (p == 0) ? fetch_data_0 : fetch_data_1, exp_word[p]);
                pending[p] = 1'b0;
                completed++;
            end
        end
    end

    initial begin
        #(RUN_CYCLES * PERIOD);
        stop_on_error("timeout: the fetch sequence did not finish in time");
    end

    ///////////////////////////////////////////////////////////////////////
    // test sequence
    ///////////////////////////////////////////////////////////////////////
    initial begin
        fetch_req_0    = 1'b0;
        fetch_addr_0   = '0;
        fetch_thread_0 = '0;
        fetch_req_1    = 1'b0;
        fetch_addr_1   = '0;
        fetch_thread_1 = '0;
        mem_wr_en      = 1'b0;
        mem_wr_line    = '0;
        mem_wr_data    = '0;
        for (int p = 0; p < 2; p++) begin
            pending[p] = 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                m_lru[p][s]      = 1'b0;
                m_valid[p][0][s] = 1'b0;
                m_valid[p][1][s] = 1'b0;
            end
        end

        wait (arst_n === 1'b1);
        @(negedge clk);
        check_flag("fetch_rdy_0 after reset", fetch_rdy_0, 1'b0);
        check_flag("fetch_busy_0 after reset", fetch_busy_0, 1'b0);
        check_flag("fetch_rdy_1 after reset", fetch_rdy_1, 1'b0);
        check_flag("fetch_busy_1 after reset", fetch_busy_1, 1'b0);
        load_memory();

        // cold miss, then hit in the same line
        fetch(0, make_addr(20'h1, 8'h10, 2'd2), 2'd0);
        fetch(0, make_addr(20'h1, 8'h10, 2'd3), 2'd0);

        // same address under another thread misses
        fetch(0, make_addr(20'h1, 8'h10, 2'd0), 2'd1);
        fetch(0, make_addr(20'h1, 8'h10, 2'd1), 2'd1);
        fetch(0, make_addr(20'h1, 8'h10, 2'd1), 2'd0);

        // three lines in one set, B becomes lru and is evicted by C
        fetch(1, make_addr(20'h2, 8'h40, 2'd0), 2'd0);
        fetch(1, make_addr(20'h3, 8'h40, 2'd1), 2'd0);
        fetch(1, make_addr(20'h2, 8'h40, 2'd2), 2'd0);
        fetch(1, make_addr(20'h5, 8'h40, 2'd3), 2'd0);
        fetch(1, make_addr(20'h2, 8'h40, 2'd0), 2'd0);   // kept, hits
        fetch(1, make_addr(20'h3, 8'h40, 2'd1), 2'd0);   // evicted, misses

        // both ports miss in the same cycle
        fork
            fetch(0, make_addr(20'h7, 8'h80, 2'd1), 2'd2);
            fetch(1, make_addr(20'h7, 8'h80, 2'd1), 2'd2);
        join
        fork
            fetch(0, make_addr(20'h9, 8'h91, 2'd3), 2'd3);
            fetch(1, make_addr(20'hA, 8'h92, 2'd0), 2'd1);
        join

        // random traffic over a few sets and tags to force reuse
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < N_RAND; i++) begin
                rand_addr[p][i] = make_addr(tag_t'($random(seed) & 3),
                                            index_t'($random(seed) & 7),
                                            word_sel_t'($random(seed) & 3));
                rand_thr[p][i]  = thread_t'($random(seed) & 1);
            end
        end
        fork
            begin
                for (int i = 0; i < N_RAND; i++) fetch(0, rand_addr[0][i], rand_thr[0][i]);
            end
            begin
                for (int i = 0; i < N_RAND; i++) fetch(1, rand_addr[1][i], rand_thr[1][i]);
            end
        join

        @(posedge clk);
        if (completed == issued && !pending[0] && !pending[1]) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_on_error($sformatf("only %0d of %0d fetches completed", completed, issued));
        end
    end

endmodule

// File: tests/tb_clock_gen.sv
/*
 * Free running testbench clock and active low reset.
 * Reset is released on a falling edge, clear of the active edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: hdl/icache_top.sv
/*
 * Two fetch ports, each with its own two-way L1 instruction cache,
 * sharing one L2 backing memory through a round-robin arbiter.
 * No coherence with the memory write port: load memory before fetching.
 */
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int L2_LATENCY = 4,
    parameter int MEM_LINES  = 1024
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fetch_req_0,
    input  addr_t      fetch_addr_0,
    input  thread_t    fetch_thread_0,
    output logic       fetch_rdy_0,
    output word_t      fetch_data_0,
    output logic       fetch_hit_0,
    output logic       fetch_busy_0,
    input  logic       fetch_req_1,
    input  addr_t      fetch_addr_1,
    input  thread_t    fetch_thread_1,
    output logic       fetch_rdy_1,
    output word_t      fetch_data_1,
    output logic       fetch_hit_1,
    output logic       fetch_busy_1,
    input  logic       mem_wr_en,
    input  line_addr_t mem_wr_line,
    input  line_t      mem_wr_data
);

    logic       f_req    [2];
    addr_t      f_addr   [2];
    thread_t    f_thread [2];
    logic       f_rdy    [2];
    word_t      f_data   [2];
    logic       f_hit    [2];
    logic       f_busy   [2];
    logic       rd_en;
    line_addr_t rd_line;
    logic       rd_valid;
    line_t      rd_data;

    l2_bus_if l2_bus [2] ();

    //////////////////////////////////////////////////////////////////////
    // fetch port bundling
    //////////////////////////////////////////////////////////////////////
    assign f_req[0]     = fetch_req_0;
    assign f_addr[0]    = fetch_addr_0;
    assign f_thread[0]  = fetch_thread_0;
    assign f_req[1]     = fetch_req_1;
    assign f_addr[1]    = fetch_addr_1;
    assign f_thread[1]  = fetch_thread_1;
    assign fetch_rdy_0  = f_rdy[0];
    assign fetch_data_0 = f_data[0];
    assign fetch_hit_0  = f_hit[0];
    assign fetch_busy_0 = f_busy[0];
    assign fetch_rdy_1  = f_rdy[1];
    assign fetch_data_1 = f_data[1];
    assign fetch_hit_1  = f_hit[1];
    assign fetch_busy_1 = f_busy[1];

    for (genvar p = 0; p < 2; p++) begin : g_slice
        index_t                    rd_index;
        logic                      rd_en;
        tag_entry_t [NUM_WAYS-1:0] tag_rd;
        logic                      lru_rd;
        line_t [NUM_WAYS-1:0]      data_rd;
        logic                      fill_en;
        logic                      fill_way;
        index_t                    fill_index;
        tag_t                      fill_tag;
        thread_t                   fill_thread;
        line_t                     fill_data;
        logic                      touch_en;
        logic                      touch_way;

        icache_ctrl i_ctrl (
            .fetch_req    (f_req[p]),
            .fetch_addr   (f_addr[p]),
            .fetch_thread (f_thread[p]),
            .fetch_rdy    (f_rdy[p]),
            .fetch_data   (f_data[p]),
            .fetch_hit    (f_hit[p]),
            .fetch_busy   (f_busy[p]),
            .l2           (l2_bus[p]),
            .*
        );

        icache_tag_array i_tags (.*);

        icache_data_array i_data (.*);
    end

    l2_arbiter i_arbiter (
        .clk      (clk),
        .arst_n   (arst_n),
        .port0    (l2_bus[0]),
        .port1    (l2_bus[1]),
        .rd_en    (rd_en),
        .rd_line  (rd_line),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    l2_memory #(
        .L2_LATENCY (L2_LATENCY),
        .MEM_LINES  (MEM_LINES)
    ) i_memory (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (mem_wr_en),
        .wr_line  (mem_wr_line),
        .wr_data  (mem_wr_data),
        .rd_en    (rd_en),
        .rd_line  (rd_line),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

// File: hdl/l2_memory.sv
/*
 * Line-wide backing store with a fixed read latency of L2_LATENCY (>= 1).
 * Line addresses wrap modulo MEM_LINES. Writes land one cycle after wr_en.
 * Cached lines are not updated by writes, so load memory before fetching.
 */
`timescale 1ns/1ps

module l2_memory import icache_pkg::*; #(
    parameter int L2_LATENCY = 4,
    parameter int MEM_LINES  = 1024
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_en,
    input  line_addr_t wr_line,
    input  line_t      wr_data,
    input  logic       rd_en,
    input  line_addr_t rd_line,
    output logic       rd_valid,
    output line_t      rd_data
);

    line_t                 mem       [MEM_LINES];
    line_t                 pipe_data [L2_LATENCY];
    logic [L2_LATENCY-1:0] pipe_vld;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_line % MEM_LINES] <= wr_data;
        end
        pipe_data[0] <= mem[rd_line % MEM_LINES];
        for (int s = 1; s < L2_LATENCY; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld[0] <= rd_en;
            for (int s = 1; s < L2_LATENCY; s++) begin
                pipe_vld[s] <= pipe_vld[s-1];
            end
        end
    end

    assign rd_valid = pipe_vld[L2_LATENCY-1];
    assign rd_data  = pipe_data[L2_LATENCY-1];

endmodule

// File: hdl/l2_arbiter.sv
/*
 * Round-robin arbiter of the shared L2 refill bus for two caches.
 * Grants only while no read is outstanding, so one refill is in flight.
 */
`timescale 1ns/1ps

module l2_arbiter import icache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    l2_bus_if.arbiter  port0,
    l2_bus_if.arbiter  port1,
    output logic       rd_en,
    output line_addr_t rd_line,
    input  logic       rd_valid,
    input  line_t      rd_data
);

    logic busy;   // read outstanding
    logic owner;  // port of the outstanding read
    logic prio;   // port favoured on a tie
    logic pick;

    // port 1 wins when alone or when both ask and it holds priority
    assign pick    = port1.req && (!port0.req || prio);
    assign rd_en   = !busy && (port0.req || port1.req);
    assign rd_line = pick ? port1.req_line : port0.req_line;

    assign port0.gnt = rd_en && !pick;
    assign port1.gnt = rd_en && pick;

    assign port0.rsp_valid = rd_valid && !owner;
    assign port1.rsp_valid = rd_valid && owner;
    assign port0.rsp_line  = rd_data;
    assign port1.rsp_line  = rd_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (rd_en) begin
            busy  <= 1'b1;
            owner <= pick;
            prio  <= ~pick;        // other port next
        end else if (rd_valid) begin
            busy <= 1'b0;
        end
    end

    // a granted cache drops req, so one grant gives one read
    a_req_drop0: assert property (@(posedge clk) disable iff (!arst_n)
        port0.gnt |=> !port0.req);

    a_req_drop1: assert property (@(posedge clk) disable iff (!arst_n)
        port1.gnt |=> !port1.req);

    a_rsp_owned: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> busy);

endmodule

// File: hdl/icache_ctrl.sv
/*
 * Fetch FSM of one L1 instruction cache. One fetch in flight, no back-pressure:
 * fetch_req must stay low while fetch_busy is high.
 * A hit needs valid, tag match and the stored thread id equal to the fetch thread.
 * Hit returns 2 cycles after the request, a miss refills through the L2 bus.
 */
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      fetch_req,
    input  addr_t                     fetch_addr,
    input  thread_t                   fetch_thread,
    output logic                      fetch_rdy,
    output word_t                     fetch_data,
    output logic                      fetch_hit,
    output logic                      fetch_busy,
    output index_t                    rd_index,
    output logic                      rd_en,
    input  tag_entry_t [NUM_WAYS-1:0] tag_rd,
    input  logic                      lru_rd,
    input  line_t [NUM_WAYS-1:0]      data_rd,
    output logic                      fill_en,
    output logic                      fill_way,
    output index_t                    fill_index,
    output tag_t                      fill_tag,
    output thread_t                   fill_thread,
    output line_t                     fill_data,
    output logic                      touch_en,
    output logic                      touch_way,
    l2_bus_if.cache                   l2
);

    ic_state_t           state;
    addr_t               req_addr;     // latched fetch address
    thread_t             req_thread;
    logic                victim_way;
    line_t               refill_line;
    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_any;
    logic                hit_way;
    logic                pick_way;

    // array read starts on the request edge
    assign rd_en    = (state == ic_idle) && fetch_req;
    assign rd_index = addr_index(fetch_addr);

    //////////////////////////////////////////////////////////////////////
    // hit detection and victim choice
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = tag_rd[w].valid
                      && (tag_rd[w].tag == addr_tag(req_addr))
                      && (tag_rd[w].thread == req_thread);
        end
    end

    assign hit_any = |way_hit;
    assign hit_way = way_hit[1];

    // invalid way first, then the lru way
    assign pick_way = !tag_rd[0].valid ? 1'b0 :
                      !tag_rd[1].valid ? 1'b1 : lru_rd;

    assign touch_en  = (state == ic_lookup) && hit_any;
    assign touch_way = hit_way;

    assign fill_en     = (state == ic_fill);
    assign fill_way    = victim_way;
    assign fill_index  = addr_index(req_addr);   // also the touch set
    assign fill_tag    = addr_tag(req_addr);
    assign fill_thread = req_thread;
    assign fill_data   = refill_line;

    assign l2.req      = (state == ic_wait_grant);
    assign l2.req_line = req_addr[29:2];

    assign fetch_busy = (state != ic_idle) || fetch_rdy;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ic_idle;
            fetch_rdy  <= 1'b0;
            fetch_hit  <= 1'b0;
            victim_way <= 1'b0;
        end else begin
            fetch_rdy <= 1'b0;
            case (state)
                ic_idle: begin
                    if (fetch_req) state <= ic_lookup;
                end
                ic_lookup: begin
                    if (hit_any) begin
                        fetch_rdy <= 1'b1;
                        fetch_hit <= 1'b1;
                        state     <= ic_idle;
                    end else begin
                        victim_way <= pick_way;
                        state      <= ic_wait_grant;
                    end
                end
                ic_wait_grant: begin
                    if (l2.gnt) state <= ic_wait_fill;
                end
                ic_wait_fill: begin
                    if (l2.rsp_valid) state <= ic_fill;
                end
                ic_fill: begin                 // line written, word returned
                    fetch_rdy <= 1'b1;
                    fetch_hit <= 1'b0;
                    state     <= ic_idle;
                end
                default: state <= ic_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_addr   <= fetch_addr;
            req_thread <= fetch_thread;
        end
        if (state == ic_wait_fill && l2.rsp_valid) begin
            refill_line <= l2.rsp_line;
        end
        if (state == ic_lookup && hit_any) begin
            fetch_data <= data_rd[hit_way][addr_word(req_addr)];
        end else if (state == ic_fill) begin
            fetch_data <= refill_line[addr_word(req_addr)];
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_req |-> !fetch_busy);

    // a line is never present in both ways
    a_single_hit: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ic_lookup) |-> !(&way_hit));

endmodule

// File: hdl/icache_data_array.sv
/*
 * Line storage for both ways, no reset, contents are valid only
 * where the tag array marks them so. Read data is registered.
 */
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; (
    input  logic                 clk,
    input  logic                 rd_en,
    input  index_t               rd_index,
    input  logic                 fill_en,
    input  logic                 fill_way,
    input  index_t               fill_index,
    input  line_t                fill_data,
    output line_t [NUM_WAYS-1:0] data_rd
);

    line_t line_mem [NUM_WAYS][NUM_SETS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[fill_way][fill_index] <= fill_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                data_rd[w] <= line_mem[w][rd_index];
            end
        end
    end

endmodule

// File: hdl/icache_tag_array.sv
/*
 * Tag, thread and valid storage for both ways, plus one LRU bit per set.
 * Read data is registered and holds while rd_en is low.
 * A touch uses fill_index as its set.
 */
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rd_en,
    input  index_t                    rd_index,
    input  logic                      fill_en,
    input  logic                      fill_way,
    input  index_t                    fill_index,
    input  tag_t                      fill_tag,
    input  thread_t                   fill_thread,
    input  logic                      touch_en,
    input  logic                      touch_way,
    output tag_entry_t [NUM_WAYS-1:0] tag_rd,
    output logic                      lru_rd
);

    tag_t                tag_mem    [NUM_WAYS][NUM_SETS];
    thread_t             thread_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid      [NUM_WAYS];
    logic [NUM_SETS-1:0] lru;  // names the least recently used way

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][fill_index]    <= fill_tag;
            thread_mem[fill_way][fill_index] <= fill_thread;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid[w] <= '0;
            end
            lru <= '0;
        end else if (fill_en) begin
            valid[fill_way][fill_index] <= 1'b1;
            lru[fill_index]             <= ~fill_way;   // new line is most recent
        end else if (touch_en) begin
            lru[fill_index] <= ~touch_way;              // hit way is most recent
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered read of both ways
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_rd <= '0;
            lru_rd <= 1'b0;
        end else if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                tag_rd[w].valid  <= valid[w][rd_index];
                tag_rd[w].thread <= thread_mem[w][rd_index];
                tag_rd[w].tag    <= tag_mem[w][rd_index];
            end
            lru_rd <= lru[rd_index];
        end
    end

endmodule

// File: hdl/l2_bus_if.sv
/*
 * One refill channel between an L1 cache and the L2 arbiter.
 * req is held until the one-cycle gnt, then a single rsp_valid strobe follows.
 */
`timescale 1ns/1ps

interface l2_bus_if import icache_pkg::*; ();

    logic       req;        // miss pending
    line_addr_t req_line;
    logic       gnt;        // one-cycle strobe
    logic       rsp_valid;  // one-cycle strobe with the line
    line_t      rsp_line;

    modport cache (
        output req,
        output req_line,
        input  gnt,
        input  rsp_valid,
        input  rsp_line
    );

    modport arbiter (
        input  req,
        input  req_line,
        output gnt,
        output rsp_valid,
        output rsp_line
    );

endinterface

// File: hdl/icache_pkg.sv
/*
 * Shared geometry, field types and FSM encoding for the instruction cache.
 * Word addressed: a fetch address carries no byte offset.
 * Lines are four 32-bit words, two ways of 256 sets.
 */
package icache_pkg;

    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 256;

    typedef logic [29:0] addr_t;       // word address
    typedef logic [1:0]  word_sel_t;   // word within a line
    typedef logic [7:0]  index_t;      // set index, addr[9:2]
    typedef logic [19:0] tag_t;        // addr[29:10]
    typedef logic [27:0] line_addr_t;  // tag and index
    typedef logic [1:0]  thread_t;
    typedef logic [31:0] word_t;
    typedef word_t [3:0] line_t;       // word 0 in the low bits

    typedef struct packed {
        logic    valid;
        thread_t thread;
        tag_t    tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        ic_idle,
        ic_lookup,
        ic_wait_grant,
        ic_wait_fill,
        ic_fill
    } ic_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[29:10];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[9:2];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[1:0];
    endfunction

endpackage
